// File: lcd_ctrl_top.f
logic/lcd_pkg.sv
logic/lcd_cmd_decode.sv
logic/lcd_bus_sequencer.sv
logic/lcd_settle_timer.sv
logic/lcd_ctrl_top.sv
tests/lcd_ctrl_asserts.sv
tests/lcd_ctrl_tb.sv

// File: logic/lcd_bus_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_bus_sequencer (
    input  wire logic                          clk,
    input  wire logic                          nrst,
    input  wire logic                          start,
    input  wire logic [lcd_pkg::data_w-1:0]    cmd_byte,
    input  wire logic [lcd_pkg::word_w-1:0]    param_word,
    input  wire logic [lcd_pkg::count_w-1:0]   param_count,
    input  wire logic                          settle,
    input  wire logic                          settle_done,
    output logic      [lcd_pkg::data_w-1:0]    outputs,
    output logic                               wrx,
    output logic                               csx,
    output logic                               dcx,
    output logic                               busy,
    output logic                               settle_start,
    output logic                               done
);

    lcd_pkg::seq_state_e state;

    logic [lcd_pkg::phase_w-1:0] phase;
    logic [lcd_pkg::count_w-1:0] bytes_left;
    logic [lcd_pkg::word_w-1:0]  shift_reg;
    logic                        settle_q;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= lcd_pkg::seq_idle;
            phase <= lcd_pkg::phase_setup;
            bytes_left <= '0;
            outputs <= '0;
            wrx <= 1'b0;
            csx <= 1'b1;
            dcx <= 1'b0;
            busy <= 1'b0;
            settle_start <= 1'b0;
            done <= 1'b0;
        end else begin
            settle_start <= 1'b0;
            done <= 1'b0;
            case (state)
                lcd_pkg::seq_idle: begin
                    if (start) begin
                        // command byte goes out first with dcx low
                        state <= lcd_pkg::seq_send;
                        phase <= lcd_pkg::phase_setup;
                        bytes_left <= param_count;
                        outputs <= cmd_byte;
                        csx <= 1'b0;
                        dcx <= 1'b0;
                        busy <= 1'b1;
                    end
                end
                lcd_pkg::seq_send: begin
                    case (phase)
                        lcd_pkg::phase_setup: begin
                            phase <= lcd_pkg::phase_hold;
                        end
                        lcd_pkg::phase_hold: begin
                            phase <= lcd_pkg::phase_strobe;
                            wrx <= 1'b1;
                        end
                        lcd_pkg::phase_strobe: begin
                            // wrx falls here, the display has sampled on its rise
                            wrx <= 1'b0;
                            phase <= lcd_pkg::phase_setup;
                            if (bytes_left != '0) begin
                                outputs <= shift_reg[lcd_pkg::word_w-1 -: lcd_pkg::data_w];
                                dcx <= 1'b1;
                                bytes_left <= bytes_left - 1'b1;
                            end else begin
                                state <= lcd_pkg::seq_finish;
                            end
                        end
                        default: begin
                            phase <= lcd_pkg::phase_setup;
                        end
                    endcase
                end
                lcd_pkg::seq_finish: begin
                    csx <= 1'b1;
                    dcx <= 1'b0;
                    if (settle_q) begin
                        // busy is held until the timer reports back
                        state <= lcd_pkg::seq_settle;
                        settle_start <= 1'b1;
                    end else begin
                        state <= lcd_pkg::seq_idle;
                        busy <= 1'b0;
                        done <= 1'b1;
                    end
                end
                lcd_pkg::seq_settle: begin
                    if (settle_done) begin
                        state <= lcd_pkg::seq_idle;
                        busy <= 1'b0;
                        done <= 1'b1;
                    end
                end
                default: begin
                    state <= lcd_pkg::seq_idle;
                end
            endcase
        end
    end

    // parameter bytes leave from the top of the word
    always_ff @(posedge clk) begin
        if ((state == lcd_pkg::seq_idle) && start) begin
            shift_reg <= param_word;
            settle_q <= settle;
        end else if ((state == lcd_pkg::seq_send) && (phase == lcd_pkg::phase_strobe) &&
                     (bytes_left != '0)) begin
            shift_reg <= shift_reg << lcd_pkg::data_w;
        end
    end

endmodule

`default_nettype wire

// File: logic/lcd_cmd_decode.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_cmd_decode (
    input  wire logic                          clk,
    input  wire logic                          nrst,
    input  wire logic [lcd_pkg::word_w-1:0]    inputs,
    input  wire logic                          enable_command,
    input  wire logic                          enable_parameter,
    input  wire logic                          done,
    output logic                               start,
    output logic      [lcd_pkg::data_w-1:0]    cmd_byte,
    output logic      [lcd_pkg::word_w-1:0]    param_word,
    output logic      [lcd_pkg::count_w-1:0]   param_count,
    output logic                               settle
);

    lcd_pkg::dec_state_e state;

    logic [lcd_pkg::count_field_w-1:0] raw_count;
    logic [lcd_pkg::count_w-1:0]       lookup_count;
    logic                              lookup_settle;
    logic                              accept_cmd;
    logic                              capture_param;

    // done frees the decoder in the same cycle, so a back-to-back command is kept
    assign accept_cmd = (state == lcd_pkg::dec_idle) ||
                        ((state == lcd_pkg::dec_wait_done) && done);
    assign capture_param = (state == lcd_pkg::dec_wait_param) && enable_parameter;

    // parameter count lookup on the incoming command word
    always_comb begin
        raw_count = inputs[lcd_pkg::count_field_lsb +: lcd_pkg::count_field_w];
        lookup_settle = 1'b0;
        case (inputs[lcd_pkg::data_w-1:0])
            lcd_pkg::cmd_caset, lcd_pkg::cmd_paset: lookup_count = lcd_pkg::params_addr;
            lcd_pkg::cmd_ramwr, lcd_pkg::cmd_ramrd: lookup_count = lcd_pkg::params_mem;
            lcd_pkg::cmd_pixfmt, lcd_pkg::cmd_madctl: lookup_count = lcd_pkg::params_cfg;
            lcd_pkg::cmd_swreset, lcd_pkg::cmd_sleep_in, lcd_pkg::cmd_sleep_out: begin
                lookup_count = lcd_pkg::params_none;
                lookup_settle = 1'b1;
            end
            lcd_pkg::cmd_nop, lcd_pkg::cmd_disp_off, lcd_pkg::cmd_disp_on: begin
                lookup_count = lcd_pkg::params_none;
            end
            default: begin
                // unknown command, count from the host capped at four
                if (raw_count > lcd_pkg::max_params) begin
                    lookup_count = lcd_pkg::params_cap;
                end else begin
                    lookup_count = raw_count[lcd_pkg::count_w-1:0];
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= lcd_pkg::dec_idle;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            if (accept_cmd) begin
                state <= enable_command ? lcd_pkg::dec_wait_param : lcd_pkg::dec_idle;
            end else if (capture_param) begin
                state <= lcd_pkg::dec_wait_done;
                start <= 1'b1;
            end
        end
    end

    // latched command and parameters
    always_ff @(posedge clk) begin
        if (accept_cmd && enable_command) begin
            cmd_byte <= inputs[lcd_pkg::data_w-1:0];
            param_count <= lookup_count;
            settle <= lookup_settle;
        end
        if (capture_param) begin
            param_word <= inputs;
        end
    end

endmodule

`default_nettype wire

// File: logic/lcd_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_ctrl_top (
    input  wire logic                          clk,
    input  wire logic                          nrst,
    input  wire logic [lcd_pkg::word_w-1:0]    inputs,
    input  wire logic                          enable_command,
    input  wire logic                          enable_parameter,
    output logic      [lcd_pkg::data_w-1:0]    outputs,
    output logic                               wrx,
    output logic                               csx,
    output logic                               dcx,
    output logic                               busy
);

    // decode to sequencer
    logic                          start;
    logic [lcd_pkg::data_w-1:0]    cmd_byte;
    logic [lcd_pkg::word_w-1:0]    param_word;
    logic [lcd_pkg::count_w-1:0]   param_count;
    logic                          settle;

    // sequencer handshakes with timer and decoder
    logic settle_start;
    logic settle_done;
    logic done;

    lcd_cmd_decode lcd_cmd_decode_inst (
        .clk              (clk),
        .nrst             (nrst),
        .inputs           (inputs),
        .enable_command   (enable_command),
        .enable_parameter (enable_parameter),
        .done             (done),
        .start            (start),
        .cmd_byte         (cmd_byte),
        .param_word       (param_word),
        .param_count      (param_count),
        .settle           (settle)
    );

    lcd_bus_sequencer lcd_bus_sequencer_inst (
        .clk          (clk),
        .nrst         (nrst),
        .start        (start),
        .cmd_byte     (cmd_byte),
        .param_word   (param_word),
        .param_count  (param_count),
        .settle       (settle),
        .settle_done  (settle_done),
        .outputs      (outputs),
        .wrx          (wrx),
        .csx          (csx),
        .dcx          (dcx),
        .busy         (busy),
        .settle_start (settle_start),
        .done         (done)
    );

    lcd_settle_timer lcd_settle_timer_inst (
        .clk          (clk),
        .nrst         (nrst),
        .settle_start (settle_start),
        .settle_done  (settle_done)
    );

endmodule

`default_nettype wire

// File: logic/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

    // bus and host word widths
    localparam int unsigned data_w = 8;
    localparam int unsigned word_w = 32;

    // command word layout, count field sits above the command byte
    localparam int unsigned count_field_lsb = 8;
    localparam int unsigned count_field_w = 4;

    // parameter byte count limits
    localparam int unsigned max_params = 4;
    localparam int unsigned count_w = 3;
    localparam logic [count_w-1:0] params_cap = count_w'(max_params);

    // per-command parameter counts
    localparam logic [count_w-1:0] params_addr = 3'd4;
    localparam logic [count_w-1:0] params_mem = 3'd2;
    localparam logic [count_w-1:0] params_cfg = 3'd1;
    localparam logic [count_w-1:0] params_none = 3'd0;

    // settle delay after reset and sleep commands
    localparam int unsigned settle_cycles = 48000;
    localparam int unsigned settle_w = 24;
    // one cycle is already spent passing settle_start into the timer
    localparam logic [settle_w-1:0] settle_load = settle_w'(settle_cycles - 1);

    // display command codes
    localparam logic [data_w-1:0] cmd_nop = 8'h00;
    localparam logic [data_w-1:0] cmd_swreset = 8'h01;
    localparam logic [data_w-1:0] cmd_sleep_in = 8'h10;
    localparam logic [data_w-1:0] cmd_sleep_out = 8'h11;
    localparam logic [data_w-1:0] cmd_disp_off = 8'h28;
    localparam logic [data_w-1:0] cmd_disp_on = 8'h29;
    localparam logic [data_w-1:0] cmd_caset = 8'h2A;
    localparam logic [data_w-1:0] cmd_paset = 8'h2B;
    localparam logic [data_w-1:0] cmd_ramwr = 8'h2C;
    localparam logic [data_w-1:0] cmd_ramrd = 8'h2E;
    localparam logic [data_w-1:0] cmd_madctl = 8'h36;
    localparam logic [data_w-1:0] cmd_pixfmt = 8'h3A;

    // byte phases on the bus: two setup cycles then the strobe
    localparam int unsigned phase_w = 2;
    localparam logic [phase_w-1:0] phase_setup = 2'd0;
    localparam logic [phase_w-1:0] phase_hold = 2'd1;
    localparam logic [phase_w-1:0] phase_strobe = 2'd2;

    // host word capture
    typedef enum logic [1:0] {
        dec_idle,
        dec_wait_param,
        dec_wait_done
    } dec_state_e;

    // bus sequencer
    typedef enum logic [1:0] {
        seq_idle,
        seq_send,
        seq_finish,
        seq_settle
    } seq_state_e;

endpackage

`default_nettype wire

// File: logic/lcd_settle_timer.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_settle_timer (
    input  wire logic clk,
    input  wire logic nrst,
    input  wire logic settle_start,
    output logic      settle_done
);

    logic [lcd_pkg::settle_w-1:0] count;
    logic [lcd_pkg::settle_w-1:0] count_next;

    assign count_next = count - 1'b1;

    // zero count means idle
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            count <= '0;
            settle_done <= 1'b0;
        end else begin
            settle_done <= 1'b0;
            if (settle_start) begin
                count <= lcd_pkg::settle_load;
            end else if (count != '0) begin
                count <= count_next;
                // pulse on the step into zero
                settle_done <= (count_next == '0);
            end
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the LCD controller testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=lcd_ctrl_sim
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module lcd_ctrl_tb \
    -f lcd_ctrl_top.f \
    -Mdir "$build_dir" -o "$sim_bin"
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$build_dir/$sim_bin" 2>&1 | tee "$log_file"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$log_file"; then
    echo "failure reported in $log_file"
    exit 1
fi
if ! grep -q "Simulation completed successfully" "$log_file"; then
    echo "no completion line found in $log_file"
    exit 1
fi
exit 0

// File: tests/lcd_ctrl_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_ctrl_asserts (
    input wire logic clk,
    input wire logic nrst,
    input wire logic wrx,
    input wire logic csx,
    input wire logic dcx,
    input wire logic busy
);

    // strobe only inside a chip-select window
    wrx_inside_cs: assert property (@(posedge clk) disable iff (!nrst) wrx |-> !csx)
        else $error("wrx high while csx is high");

    // data/command select holds through the strobe
    dcx_stable_on_strobe: assert property (@(posedge clk) disable iff (!nrst)
        wrx |-> $stable(dcx))
        else $error("dcx changed while wrx was high");

    // chip select already released when busy drops
    busy_falls_after_cs: assert property (@(posedge clk) disable iff (!nrst)
        $fell(busy) |-> csx)
        else $error("busy fell while csx was still low");

endmodule

bind lcd_bus_sequencer lcd_ctrl_asserts lcd_ctrl_asserts_inst (
    .clk  (clk),
    .nrst (nrst),
    .wrx  (wrx),
    .csx  (csx),
    .dcx  (dcx),
    .busy (busy)
);

`default_nettype wire

// File: tests/lcd_ctrl_tb.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_ctrl_tb;

    localparam int busy_limit = int'(lcd_pkg::settle_cycles) + 100;
    localparam logic [7:0] plain_cmds [9] = '{lcd_pkg::cmd_nop, lcd_pkg::cmd_disp_off,
        lcd_pkg::cmd_disp_on, lcd_pkg::cmd_caset, lcd_pkg::cmd_paset, lcd_pkg::cmd_ramwr,
        lcd_pkg::cmd_ramrd, lcd_pkg::cmd_madctl, lcd_pkg::cmd_pixfmt};
    localparam logic [7:0] settle_cmds [3] = '{lcd_pkg::cmd_swreset, lcd_pkg::cmd_sleep_in,
        lcd_pkg::cmd_sleep_out};

    logic        clk;
    logic        nrst;
    logic [31:0] inputs;
    logic        enable_command;
    logic        enable_parameter;
    logic [7:0]  outputs;
    logic        wrx;
    logic        csx;
    logic        dcx;
    logic        busy;

    // bus bytes kept as {dcx, data}
    logic [8:0]  exp_q [$];
    logic [8:0]  got_q [$];
    logic [8:0]  got;
    logic [8:0]  want;
    event        capture_ev;
    logic [31:0] rng;
    int          check_errors;
    int          tests_run;
    int          tests_passed;

    lcd_ctrl_top lcd_ctrl_top_inst (
        .clk              (clk),
        .nrst             (nrst),
        .inputs           (inputs),
        .enable_command   (enable_command),
        .enable_parameter (enable_parameter),
        .outputs          (outputs),
        .wrx              (wrx),
        .csx              (csx),
        .dcx              (dcx),
        .busy             (busy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // command byte first, then parameter bytes msb first
    function automatic int expected_bytes(input logic [31:0] cmd_word,
                                          input logic [31:0] param_word,
                                          output logic [4:0][8:0] list);
        int count;
        case (cmd_word[7:0])
            lcd_pkg::cmd_caset, lcd_pkg::cmd_paset: count = 4;
            lcd_pkg::cmd_ramwr, lcd_pkg::cmd_ramrd: count = 2;
            lcd_pkg::cmd_pixfmt, lcd_pkg::cmd_madctl: count = 1;
            lcd_pkg::cmd_nop, lcd_pkg::cmd_swreset, lcd_pkg::cmd_sleep_in,
            lcd_pkg::cmd_sleep_out, lcd_pkg::cmd_disp_off, lcd_pkg::cmd_disp_on: count = 0;
            default: begin
                count = int'(cmd_word[11:8]);
                if (count > int'(lcd_pkg::max_params)) begin
                    count = int'(lcd_pkg::max_params);
                end
            end
        endcase
        list = '0;
        list[0] = {1'b0, cmd_word[7:0]};
        for (int i = 0; i < count; i++) begin
            list[i+1] = {1'b1, param_word[31-8*i -: 8]};
        end
        return count + 1;
    endfunction

    task automatic send_command(input logic [31:0] cmd_word, input logic [31:0] param_word,
                                input bit stray);
        logic [4:0][8:0] list;
        int n;
        int busy_cycles;
        int waited;
        int exp_busy;
        bit settle_cmd;
        n = expected_bytes(cmd_word, param_word, list);
        for (int i = 0; i < n; i++) begin
            exp_q.push_back(list[i]);
        end
        settle_cmd = (cmd_word[7:0] == lcd_pkg::cmd_swreset) ||
                     (cmd_word[7:0] == lcd_pkg::cmd_sleep_in) ||
                     (cmd_word[7:0] == lcd_pkg::cmd_sleep_out);
        exp_busy = settle_cmd ? 3*n + 2 + int'(lcd_pkg::settle_cycles) : 3*n + 1;
        inputs = cmd_word;
        enable_command = 1'b1;
        @(negedge clk);
        enable_command = 1'b0;
        inputs = param_word;
        enable_parameter = 1'b1;
        @(negedge clk);
        enable_parameter = 1'b0;
        // junk unknown command with four parameters for the stray pulses
        inputs = stray ? 32'h0000_04C5 : '0;
        @(negedge clk);
        assert (busy && !csx && !dcx && outputs == cmd_word[7:0]) else begin
            $display("FAIL @ %0t: command %h not on the bus one cycle after its parameters",
                     $time, cmd_word[7:0]);
            check_errors++;
        end
        busy_cycles = busy ? 1 : 0;
        waited = 0;
        while (busy && waited < busy_limit) begin
            @(negedge clk);
            waited++;
            if (busy) begin
                busy_cycles++;
            end
            enable_command = stray && (busy_cycles == 2);
            enable_parameter = stray && (busy_cycles == 4);
        end
        inputs = '0;
        assert (!busy) else begin
            $display("busy still high %0d cycles after command %h started, the DUT hangs",
                     busy_limit, cmd_word[7:0]);
            check_errors++;
        end
        assert (busy_cycles == exp_busy) else begin
            $display("FAIL @ %0t: command %h held busy %0d cycles, expected %0d",
                     $time, cmd_word[7:0], busy_cycles, exp_busy);
            check_errors++;
        end
        assert (exp_q.size() == 0) else begin
            $display("FAIL @ %0t: command %h left %0d expected bytes unsent",
                     $time, cmd_word[7:0], exp_q.size());
            check_errors++;
        end
        exp_q.delete();
    endtask

    task automatic close_test(input string name, input int errors_before);
        tests_run++;
        if (check_errors == errors_before) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            $display("test %s: %0d checks failed", name, check_errors - errors_before);
        end
    endtask

    // display samples on the rising wrx edge
    always @(posedge wrx) begin
        if (!csx) begin
            got_q.push_back({dcx, outputs});
            -> capture_ev;
        end
    end

    initial begin
        forever begin
            @(capture_ev);
            while (got_q.size() != 0) begin
                got = got_q.pop_front();
                assert (exp_q.size() != 0) else begin
                    $display("bus write %h appeared at %0t with no byte expected", got, $time);
                    check_errors++;
                end
                if (exp_q.size() != 0) begin
                    want = exp_q.pop_front();
                    assert (got == want) else begin
                        $display("FAIL @ %0t: got dcx=%b data=%h, expected dcx=%b data=%h",
                                 $time, got[8], got[7:0], want[8], want[7:0]);
                        check_errors++;
                    end
                end
            end
        end
    end

    initial begin
        int errors_before;
        logic [31:0] r;
        logic [7:0] code;
        nrst = 1'b0;
        inputs = '0;
        enable_command = 1'b0;
        enable_parameter = 1'b0;
        rng = 32'h013e79ce;
        check_errors = 0;
        tests_run = 0;
        tests_passed = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;

        errors_before = check_errors;
        assert (csx && !wrx && !dcx && !busy && outputs == 8'h00) else begin
            $display("FAIL @ %0t: bus not idle after reset", $time);
            check_errors++;
        end
        close_test("reset values", errors_before);

        // count bits above the code must be ignored for table commands
        errors_before = check_errors;
        for (int i = 0; i < 9; i++) begin
            rng = lcg_next(rng);
            r = rng;
            rng = lcg_next(rng);
            send_command({r[31:8], plain_cmds[i]}, rng, 1'b0);
        end
        close_test("table commands", errors_before);

        errors_before = check_errors;
        for (int k = 0; k < 20; k++) begin
            rng = lcg_next(rng);
            r = rng;
            code = r[7:0];
            // codes from 8'h40 up are outside the table
            if (code[7:6] == 2'b00) begin
                code[6] = 1'b1;
            end
            rng = lcg_next(rng);
            send_command({r[31:8], code}, rng, 1'b0);
        end
        close_test("unknown commands", errors_before);

        errors_before = check_errors;
        for (int i = 0; i < 3; i++) begin
            rng = lcg_next(rng);
            send_command({24'h0, settle_cmds[i]}, rng, 1'b0);
        end
        close_test("settle commands", errors_before);

        errors_before = check_errors;
        inputs = 32'h1234_5678;
        enable_parameter = 1'b1;
        @(negedge clk);
        enable_parameter = 1'b0;
        inputs = '0;
        repeat (8) begin
            @(negedge clk);
            assert (csx && !wrx && !busy) else begin
                $display("FAIL @ %0t: bus active after enable_parameter in idle", $time);
                check_errors++;
            end
        end
        rng = lcg_next(rng);
        send_command({24'h0, lcd_pkg::cmd_caset}, rng, 1'b1);
        rng = lcg_next(rng);
        send_command({24'h0, lcd_pkg::cmd_ramwr}, rng, 1'b0);
        close_test("ignored enables", errors_before);

        $display("tests run %0d, passed %0d, failed %0d, failed checks %0d",
                 tests_run, tests_passed, tests_run - tests_passed, check_errors);
        if (check_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
